// ==== verilog.f ====
+incdir+bench
hw/deser_cfg_pkg.sv
hw/deser_word_pkg.sv
hw/deser_lane.sv
hw/word_assembler.sv
hw/deser_data_top.sv
bench/deser_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the deserializer bench with Verilator and runs it from the project root.
# The run passes only if the simulation prints the pass message.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module deser_tb -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

out=$(./obj_dir/Vdeser_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "Test completed successfully"; then
	exit 0
fi
exit 1

// ==== bench/deser_model.svh ====
// Expected-word model for the deserializer bench, included inside the bench module.
// Needs deser_cfg_pkg in scope and STREAM_LEN declared before the include.
`ifndef DESER_MODEL_SVH
`define DESER_MODEL_SVH

// --------------------------------------------------
// stream store, index = position in the stream
// --------------------------------------------------
logic [CHANNEL_NUM-1:0] stream_data [STREAM_LEN];	// serial bit per channel
logic [CHANNEL_NUM-1:0] stream_slip [STREAM_LEN];	// slip request per channel

// bits before the stream start read as zero
function automatic logic stream_bit(input int c, input int n);
	if (n < 0)
		return 1'b0;
	return stream_data[n][c];
endfunction

// a pulse sampled with the frame's last bit still sees the old offset
function automatic int slip_offset(input int c, input int last_bit);
	int cnt;
	cnt = 0;
	for (int n = 0; n < last_bit; n++)
		if (stream_slip[n][c])
			cnt++;
	return cnt % DESER_WIDTH;
endfunction

// frame k with offset s covers bits k*W-s .. k*W+W-1-s
function automatic logic [DESER_WIDTH-1:0] lane_expect(input int c, input int k,
		input first_bit_e first_bit);
	logic [DESER_WIDTH-1:0] lw;
	int first;
	first = k*DESER_WIDTH - slip_offset(c, k*DESER_WIDTH + DESER_WIDTH - 1);
	for (int i = 0; i < DESER_WIDTH; i++) begin
		if (first_bit == FIRST_MSB)
			lw[DESER_WIDTH-1-i] = stream_bit(c, first + i);	// earliest on top
		else
			lw[i] = stream_bit(c, first + i);
	end
	return lw;
endfunction

function automatic logic [CHANNEL_NUM*DESER_WIDTH-1:0] word_expect(input int k,
		input first_bit_e first_bit, input chan_order_e order);
	logic [CHANNEL_NUM*DESER_WIDTH-1:0] w;
	int slot;
	for (int c = 0; c < CHANNEL_NUM; c++) begin
		slot = (order == ORDER_LITTLE) ? c : CHANNEL_NUM-1-c;	// big puts ch0 on top
		w[slot*DESER_WIDTH +: DESER_WIDTH] = lane_expect(c, k, first_bit);
	end
	return w;
endfunction

`endif

// ==== bench/deser_tb.sv ====
// Two deserializer builds on one LFSR stream, checked edge by edge against the model.
// Fixed seed, so every run drives the same bits and slip pulses.
`timescale 1ns/100ps

module deser_tb
	import deser_cfg_pkg::*, deser_word_pkg::*;
;
	localparam int FRAMES         = 150;	// frames per test
	localparam int RUN_EDGES      = FRAMES*DESER_WIDTH + DESER_WIDTH;	// one frame of tail
	localparam int STREAM_LEN     = RUN_EDGES;
	localparam int RESET_CYCLES   = 2;
	localparam int FIRST_PULSE    = DESER_WIDTH + 1;	// last bit of frame 0 at edge W
	localparam int NUM_TESTS      = 4;
	localparam int TIMEOUT_CYCLES = (NUM_TESTS * (RUN_EDGES + RESET_CYCLES + 3) * 3) / 2;

	logic       clk = 1'b0;
	logic       rst_n;
	serial_in_t serial_in;	// shared by both builds
	deser_out_t out0;	// msb first, little order
	deser_out_t out1;	// lsb first, big order

	logic [15:0] lfsr_state;
	logic [CHANNEL_NUM*DESER_WIDTH-1:0] exp_word0;	// held between pulses
	logic [CHANNEL_NUM*DESER_WIDTH-1:0] exp_word1;
	int test_checks;
	int test_errors;
	int tests_passed;
	int tests_failed;
	int cycle_count;

	`include "deser_model.svh"

	always #50 clk = ~clk;	// 100 ns period

	deser_data_top #(.FIRST_BIT(FIRST_MSB), .CHAN_ORDER(ORDER_LITTLE), .BITSLIP_ENABLE(1'b1))
		dut0 (.clk_io(clk), .rst_n(rst_n), .serial_in(serial_in), .deser_out(out0));

	deser_data_top #(.FIRST_BIT(FIRST_LSB), .CHAN_ORDER(ORDER_BIG), .BITSLIP_ENABLE(1'b1))
		dut1 (.clk_io(clk), .rst_n(rst_n), .serial_in(serial_in), .deser_out(out1));

	// --------------------------------------------------
	// random bits
	// --------------------------------------------------
	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_bits(input int count, output logic [7:0] v);
		v = '0;
		for (int i = 0; i < count; i++) begin
			v = {v[6:0], lfsr_state[15]};	// bit shifted out
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	// fills the stream store; slip on about one channel-cycle in 64
	task automatic make_stream(input bit slip_on);
		logic [7:0] v;
		for (int n = 0; n < STREAM_LEN; n++) begin
			for (int c = 0; c < CHANNEL_NUM; c++) begin
				take_bits(1, v);
				stream_data[n][c] = v[0];
				stream_slip[n][c] = 1'b0;
				if (slip_on) begin
					take_bits(6, v);
					stream_slip[n][c] = (v[5:0] == 6'd0);
				end
			end
		end
	endtask

	// --------------------------------------------------
	// checking
	// --------------------------------------------------
	task automatic compare_value(input string test_name, input string what,
			input logic [31:0] expected, input logic [31:0] actual);
		test_checks++;
		if (expected !== actual) begin
			test_errors++;
			$display("Fail %s: %s expected %h actual %h", test_name, what, expected, actual);
		end
	endtask

	task automatic check_edge(input string name, input int e, input bit chk0, input bit chk1);
		logic exp_valid;
		exp_valid = (e >= FIRST_PULSE) && ((e - FIRST_PULSE) % DESER_WIDTH == 0);
		compare_value(name, "dut0 word_valid", 32'(exp_valid), 32'(out0.word_valid));
		compare_value(name, "dut1 word_valid", 32'(exp_valid), 32'(out1.word_valid));
		if (e < FIRST_PULSE) begin
			compare_value(name, "dut0 word before first pulse", 32'(0), 32'(out0.word.flat));
			compare_value(name, "dut1 word before first pulse", 32'(0), 32'(out1.word.flat));
		end else begin
			if (exp_valid) begin
				exp_word0 = word_expect((e - FIRST_PULSE) / DESER_WIDTH, FIRST_MSB, ORDER_LITTLE);
				exp_word1 = word_expect((e - FIRST_PULSE) / DESER_WIDTH, FIRST_LSB, ORDER_BIG);
			end
			if (chk0)
				compare_value(name, "dut0 word", 32'(exp_word0), 32'(out0.word.flat));
			if (chk1)
				compare_value(name, "dut1 word", 32'(exp_word1), 32'(out1.word.flat));
		end
	endtask

	// --------------------------------------------------
	// one test, reset then the whole stream
	// --------------------------------------------------
	task automatic drive_bits(input int n);
		if (n < STREAM_LEN) begin
			serial_in.data    <= stream_data[n];
			serial_in.bitslip <= stream_slip[n];
		end else begin
			serial_in <= '0;
		end
	endtask

	task automatic run_test(input string name, input bit slip_on, input bit chk0, input bit chk1);
		int max_slips;
		int slips;
		test_checks = 0;
		test_errors = 0;
		make_stream(slip_on);
		@(posedge clk);
		rst_n <= 1'b0;
		serial_in <= '0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		drive_bits(0);	// sampled on the first edge after release
		@(negedge clk);
		check_edge(name, 0, chk0, chk1);
		for (int e = 1; e <= RUN_EDGES; e++) begin
			@(posedge clk);
			drive_bits(e);
			@(negedge clk);	// outputs settled
			check_edge(name, e, chk0, chk1);
		end
		max_slips = 0;
		for (int c = 0; c < CHANNEL_NUM; c++) begin
			slips = 0;
			for (int n = 0; n < FRAMES*DESER_WIDTH - 1; n++)
				if (stream_slip[n][c])
					slips++;
			if (slips > max_slips)
				max_slips = slips;
		end
		if (slip_on && max_slips < DESER_WIDTH) begin
			test_errors++;	// offset never wrapped, stream too quiet
			$display("%s: no channel slipped often enough to wrap its offset", name);
		end
		$display("%-14s %0d checks, %0d errors", name, test_checks, test_errors);
		if (test_errors == 0)
			tests_passed++;
		else
			tests_failed++;
	endtask

	// --------------------------------------------------
	// main sequence and timeout
	// --------------------------------------------------
	initial begin
		rst_n = 1'b0;
		serial_in = '0;
		lfsr_state = 16'd37121;
		exp_word0 = '0;
		exp_word1 = '0;
		tests_passed = 0;
		tests_failed = 0;
		run_test("reset_cadence", 1'b0, 1'b0, 1'b0);	// valid timing and reset zeros only
		run_test("msb_little", 1'b0, 1'b1, 1'b0);
		run_test("lsb_big", 1'b0, 1'b0, 1'b1);
		run_test("bitslip", 1'b1, 1'b1, 1'b1);
		$display("tests: %0d passing, %0d failing", tests_passed, tests_failed);
		if (tests_failed == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

	initial cycle_count = 0;

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("run stopped after %0d cycles without finishing the tests", cycle_count);
			$display("Test failed");
			$finish;
		end
	end

endmodule

// ==== hw/deser_data_top.sv ====
// Multi-channel deserializer, serial and parallel side both on clk_io.
// Word for a frame appears one cycle after the edge that samples its last bit.
// All lanes share one frame boundary from the assembler.
`timescale 1ns/100ps

module deser_data_top
	import deser_cfg_pkg::*, deser_word_pkg::*;
#(
	parameter first_bit_e  FIRST_BIT      = FIRST_MSB,	// bit order in each lane word
	parameter chan_order_e CHAN_ORDER     = ORDER_LITTLE,	// channel order in the word
	parameter bit          BITSLIP_ENABLE = 1'b1	// per-channel word alignment
) (
	input  logic       clk_io,	// bit clock, also the parallel clock
	input  logic       rst_n,
	input  serial_in_t serial_in,	// serial bits and slip requests
	output deser_out_t deser_out	// word and valid pulse
);

	// --------------------------------------------------
	// internal nets
	// --------------------------------------------------
	lane_t [CHANNEL_NUM-1:0] lane_words;	// per-channel words, index = channel
	logic                    frame_end;	// shared boundary

	// --------------------------------------------------
	// lanes
	// --------------------------------------------------
	for (genvar c = 0; c < CHANNEL_NUM; c++) begin : lane
		deser_lane #(
			.FIRST_BIT      (FIRST_BIT),
			.BITSLIP_ENABLE (BITSLIP_ENABLE)
		) u_lane (
			.clk_io     (clk_io),
			.rst_n      (rst_n),
			.serial_bit (serial_in.data[c]),
			.bitslip    (serial_in.bitslip[c]),
			.frame_end  (frame_end),
			.lane_word  (lane_words[c])
		);
	end

	// --------------------------------------------------
	// assembler
	// --------------------------------------------------
	// also the frame counter, so it drives frame_end back into the lanes
	word_assembler #(
		.CHAN_ORDER (CHAN_ORDER)
	) asm0 (
		.clk_io     (clk_io),
		.rst_n      (rst_n),
		.lane_words (lane_words),
		.frame_end  (frame_end),
		.deser_out  (deser_out)
	);

endmodule

// ==== hw/word_assembler.sv ====
// Owns the frame counter for all lanes and builds the output word.
// word_valid pulses one cycle per frame; no back-pressure, a missed pulse loses the word.
`timescale 1ns/100ps

module word_assembler
	import deser_cfg_pkg::*, deser_word_pkg::*;
#(
	parameter chan_order_e CHAN_ORDER = ORDER_LITTLE	// slot order of the channels
) (
	input  logic                    clk_io,
	input  logic                    rst_n,
	input  lane_t [CHANNEL_NUM-1:0] lane_words,	// from the lanes, index = channel
	output logic                    frame_end,	// to every lane
	output deser_out_t              deser_out
);

	localparam int CNT_BITS = $clog2(DESER_WIDTH);

	logic [CNT_BITS-1:0] frame_cnt;	// bit position inside the frame
	logic                frame_end_q;	// lanes hold a fresh word this cycle
	word_u               ordered;	// lanes placed into their slots

	// --------------------------------------------------
	// frame counter
	// --------------------------------------------------
	always_ff @(posedge clk_io or negedge rst_n) begin
		if (!rst_n) begin
			frame_cnt <= '0;
		end else if (frame_cnt == CNT_BITS'(DESER_WIDTH-1)) begin
			frame_cnt <= '0;	// next frame starts
		end else begin
			frame_cnt <= frame_cnt + 1'b1;
		end
	end

	// last cycle of the frame, the lanes register on the edge that closes it
	assign frame_end = (frame_cnt == CNT_BITS'(DESER_WIDTH-1));

	always_ff @(posedge clk_io or negedge rst_n) begin
		if (!rst_n)
			frame_end_q <= 1'b0;
		else
			frame_end_q <= frame_end;	// lane words settle one edge later
	end

	// --------------------------------------------------
	// channel order
	// --------------------------------------------------
	always_comb begin
		for (int c = 0; c < CHANNEL_NUM; c++) begin
			if (CHAN_ORDER == ORDER_LITTLE)
				ordered.slot[c] = lane_words[c];	// ch0 low
			else
				ordered.slot[c] = lane_words[CHANNEL_NUM-1-c];	// ch0 high
		end
	end

	// --------------------------------------------------
	// output register
	// --------------------------------------------------
	always_ff @(posedge clk_io or negedge rst_n) begin
		if (!rst_n) begin
			deser_out <= '0;	// word zero, valid low
		end else begin
			deser_out.word_valid <= frame_end_q;	// one pulse per frame
			if (frame_end_q)
				deser_out.word <= ordered;	// held until the next pulse
		end
	end

	// never a two-cycle pulse, whatever the frame length
	a_valid_single: assert property (@(posedge clk_io) disable iff (!rst_n)
		deser_out.word_valid |=> !deser_out.word_valid)
		else $error("word_valid high on two consecutive cycles");

	// pulse comes from the frame boundary the lanes saw, two edges earlier
	a_valid_after_frame: assert property (@(posedge clk_io) disable iff (!rst_n)
		$rose(deser_out.word_valid) |-> $past(frame_end, 2))
		else $error("word_valid rose without a matching frame_end");

endmodule

// ==== hw/deser_lane.sv ====
// One serial channel. Takes a bit each clk_io cycle and cuts a lane word at frame_end.
// Bits before the first one after reset read as zero.
// A bitslip pulse moves the boundary one bit earlier, wrapping at DESER_WIDTH.
`timescale 1ns/100ps

module deser_lane
	import deser_cfg_pkg::*, deser_word_pkg::*;
#(
	parameter first_bit_e FIRST_BIT      = FIRST_MSB,	// bit order inside the lane word
	parameter bit         BITSLIP_ENABLE = 1'b1	// 0 ignores bitslip
) (
	input  logic  clk_io,
	input  logic  rst_n,
	input  logic  serial_bit,	// this cycle's bit
	input  logic  bitslip,	// slip request, one cycle
	input  logic  frame_end,	// last cycle of the frame, from assembler
	output lane_t lane_word	// updated at the frame_end edge
);

	// history plus the live bit holds the current frame and the W-1 bits before it
	// which covers any offset up to DESER_WIDTH-1
	localparam int HIST_W = 2*DESER_WIDTH - 2;
	localparam int SRC_W  = HIST_W + 1;

	logic [HIST_W-1:0]    hist;	// hist[0] is the previous bit
	logic [SRC_W-1:0]     src;	// src[0] is the live bit
	logic [SLIP_BITS-1:0] slip;	// boundary offset, bits earlier
	lane_t                win;	// selected window, earliest bit on top
	lane_t                ordered;	// window in output bit order

	// --------------------------------------------------
	// bit history
	// --------------------------------------------------
	always_ff @(posedge clk_io or negedge rst_n) begin
		if (!rst_n) begin
			hist <= '0;	// pre-stream bits read as zero
		end else begin
			hist <= {hist[HIST_W-2:0], serial_bit};
		end
	end

	assign src = {hist, serial_bit};

	// --------------------------------------------------
	// slip offset
	// --------------------------------------------------
	// a frame ending on the slip edge still uses the old offset
	// the window below reads slip before this update lands
	always_ff @(posedge clk_io or negedge rst_n) begin
		if (!rst_n) begin
			slip <= '0;
		end else if (BITSLIP_ENABLE && bitslip) begin
			if (slip == SLIP_BITS'(DESER_WIDTH-1))
				slip <= '0;	// wrap
			else
				slip <= slip + 1'b1;
		end
	end

	// --------------------------------------------------
	// window select and bit order
	// --------------------------------------------------
	assign win = src[int'(slip) +: DESER_WIDTH];	// s bits further back in the stream

	always_comb begin
		if (FIRST_BIT == FIRST_MSB) begin
			ordered = win;
		end else begin
			for (int i = 0; i < DESER_WIDTH; i++)
				ordered[i] = win[DESER_WIDTH-1-i];	// earliest bit to bit 0
		end
	end

	// lane word, loaded once per frame at the boundary
	always_ff @(posedge clk_io) begin
		if (frame_end)
			lane_word <= ordered;
	end

	// offset must never leave 0..DESER_WIDTH-1 across any slip sequence
	a_slip_range: assert property (@(posedge clk_io) disable iff (!rst_n)
		slip < SLIP_BITS'(DESER_WIDTH))
		else $error("lane slip offset out of range: %0d", slip);

endmodule

// ==== hw/deser_word_pkg.sv ====
// Data types carried between the lanes, the assembler and the outside.
// The word union is written by lane slots and read as one flat bus.

package deser_word_pkg;

	import deser_cfg_pkg::*;

	// --------------------------------------------------
	// lane and word
	// --------------------------------------------------

	// one channel's parallel word
	typedef logic [DESER_WIDTH-1:0] lane_t;

	// full output word, two views of the same bits
	// slot[0] sits in the low bits of flat
	typedef union packed {
		logic [CHANNEL_NUM*DESER_WIDTH-1:0] flat;	// as seen by the consumer
		lane_t [CHANNEL_NUM-1:0]            slot;	// as filled by the assembler
	} word_u;

	// --------------------------------------------------
	// ports
	// --------------------------------------------------

	// serial side, sampled on clk_io
	typedef struct packed {
		logic [CHANNEL_NUM-1:0] data;	// one bit per channel per clock
		logic [CHANNEL_NUM-1:0] bitslip;	// one-cycle slip request per channel
	} serial_in_t;

	// parallel side
	typedef struct packed {
		logic  word_valid;	// one-cycle pulse per frame
		word_u word;	// holds until next pulse
	} deser_out_t;

endpackage

// ==== hw/deser_cfg_pkg.sv ====
// Sizing and ordering choices shared by every block of the deserializer.
// DESER_WIDTH and CHANNEL_NUM size the packed word types, so change them here only.
// SLIP_BITS must hold DESER_WIDTH-1.

package deser_cfg_pkg;

	// --------------------------------------------------
	// sizes
	// --------------------------------------------------
	localparam int DESER_WIDTH = 6;	// bits per lane word
	localparam int CHANNEL_NUM = 4;	// serial channels
	localparam int SLIP_BITS   = $clog2(DESER_WIDTH);	// slip offset 0..DESER_WIDTH-1

	// --------------------------------------------------
	// ordering options
	// --------------------------------------------------

	// where the earliest bit of a frame lands in the lane word
	typedef enum logic {
		FIRST_MSB = 1'b0,	// earliest bit in top bit
		FIRST_LSB = 1'b1	// earliest bit in bit 0
	} first_bit_e;

	// where each channel lands in the packed output word
	typedef enum logic {
		ORDER_LITTLE = 1'b0,	// ch0 in lowest slot
		ORDER_BIG    = 1'b1	// ch0 in highest slot
	} chan_order_e;

endpackage
